// File: common/soc_periph_settings.svh
////////////////////
// peripheral subsystem settings
// bus widths, address map, register offsets and event line positions
////////////////////
`ifndef SOC_PERIPH_SETTINGS_SVH
`define SOC_PERIPH_SETTINGS_SVH

`define SOC_APB_ADDR_WIDTH 32
`define SOC_APB_DATA_WIDTH 32
`define SOC_NGPIO          32
`define SOC_EVNT_WIDTH     8
`define SOC_EVNT_NUM       8
`define SOC_EVT_FIFO_DEPTH 4

// 4 KiB regions
`define SOC_GPIO_BASE      32'h1A10_1000
`define SOC_EVTGEN_BASE    32'h1A10_6000
`define SOC_REGION_BITS    12

// gpio register offsets
`define SOC_GPIO_DIR       12'h000
`define SOC_GPIO_IN        12'h004
`define SOC_GPIO_OUT       12'h008
`define SOC_GPIO_INTEN     12'h00C
`define SOC_GPIO_INTSTATUS 12'h010

// event generator register offsets
`define SOC_EVT_MASK       12'h000
`define SOC_EVT_SW         12'h004
`define SOC_EVT_ERR        12'h008

// event ids, 4 to 7 are software only
`define SOC_EVT_ID_DMA_PE  0
`define SOC_EVT_ID_DMA_IRQ 1
`define SOC_EVT_ID_REF     2
`define SOC_EVT_ID_GPIO    3

// fabric controller event lines
`define SOC_FC_LINE_DMA_PE  8
`define SOC_FC_LINE_DMA_IRQ 9
`define SOC_FC_LINE_REF     14
`define SOC_FC_LINE_GPIO    15
`define SOC_FC_LINE_ERR     29

`endif

// File: common/soc_periph_pkg.sv
////////////////////
// peripheral subsystem types
// bus words, gpio words and event ids shared by all blocks
////////////////////
`include "soc_periph_settings.svh"

package soc_periph_pkg;

    // apb bus words
    typedef logic [`SOC_APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`SOC_APB_DATA_WIDTH-1:0] apb_data_t;

    // one bit per gpio pin
    typedef logic [`SOC_NGPIO-1:0] gpio_word_t;

    // event id as sent to the fabric controller
    typedef logic [`SOC_EVNT_WIDTH-1:0] event_id_t;

    // one bit per event source
    typedef logic [`SOC_EVNT_NUM-1:0] event_vec_t;

    // fabric controller event lines
    typedef logic [31:0] fc_lines_t;

endpackage

// File: common/apb_if.sv
////////////////////
// apb bus between the decoder and one peripheral
// the peripheral drives prdata, pready and pslverr
////////////////////
`timescale 1ns/1ns

interface apb_if;

    soc_periph_pkg::apb_addr_t paddr;
    soc_periph_pkg::apb_data_t pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
    soc_periph_pkg::apb_data_t prdata;
    logic                      pready;
    logic                      pslverr;

    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output prdata, pready, pslverr
    );

endinterface

// File: src/periph_apb_decoder.sv
////////////////////
// apb address decoder
// selects the gpio or event generator region and muxes
// the response, unmapped accesses end with an error
////////////////////
`timescale 1ns/1ns
`include "soc_periph_settings.svh"

module periph_apb_decoder (
    input  logic                      clk_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    apb_if.master                     gpio_bus,
    apb_if.master                     evtgen_bus
);

    localparam int AW = `SOC_APB_ADDR_WIDTH;
    localparam int RB = `SOC_REGION_BITS;
    localparam soc_periph_pkg::apb_addr_t GPIO_BASE   = `SOC_GPIO_BASE;
    localparam soc_periph_pkg::apb_addr_t EVTGEN_BASE = `SOC_EVTGEN_BASE;

    logic                      hit_gpio;
    logic                      hit_evtgen;
    soc_periph_pkg::apb_addr_t offset;

    assign hit_gpio   = (paddr_i[AW-1:RB] == GPIO_BASE[AW-1:RB]);
    assign hit_evtgen = (paddr_i[AW-1:RB] == EVTGEN_BASE[AW-1:RB]);
    assign offset     = soc_periph_pkg::apb_addr_t'(paddr_i[RB-1:0]);

    // request side, shared fields go to both slaves
    assign gpio_bus.paddr     = offset;
    assign gpio_bus.pwdata    = pwdata_i;
    assign gpio_bus.pwrite    = pwrite_i;
    assign gpio_bus.penable   = penable_i;
    assign gpio_bus.psel      = psel_i & hit_gpio;
    assign evtgen_bus.paddr   = offset;
    assign evtgen_bus.pwdata  = pwdata_i;
    assign evtgen_bus.pwrite  = pwrite_i;
    assign evtgen_bus.penable = penable_i;
    assign evtgen_bus.psel    = psel_i & hit_evtgen;

    // response mux
    always_comb begin
        prdata_o  = '0;
        pready_o  = 1'b1;
        pslverr_o = 1'b0;
        if (hit_gpio) begin
            prdata_o  = gpio_bus.prdata;
            pready_o  = gpio_bus.pready;
            pslverr_o = gpio_bus.pslverr;
        end else if (hit_evtgen) begin
            prdata_o  = evtgen_bus.prdata;
            pready_o  = evtgen_bus.pready;
            pslverr_o = evtgen_bus.pslverr;
        end else begin
            pslverr_o = psel_i & penable_i;
        end
    end

    // at most one slave sees a transfer
    assert property (@(posedge clk_i) !(gpio_bus.psel && evtgen_bus.psel))
        else $error("both peripheral selects high");

endmodule

// File: gpio/apb_gpio.sv
////////////////////
// apb gpio
// direction and output registers, synchronised input
// and rising edge interrupts
////////////////////
`timescale 1ns/1ns
`include "soc_periph_settings.svh"

module apb_gpio (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  soc_periph_pkg::gpio_word_t gpio_in_i,
    apb_if.slave                       bus,
    output soc_periph_pkg::gpio_word_t gpio_out_o,
    output soc_periph_pkg::gpio_word_t gpio_dir_o,
    output logic                       gpio_event_o
);

    localparam int RB = `SOC_REGION_BITS;

    soc_periph_pkg::gpio_word_t dir_q;
    soc_periph_pkg::gpio_word_t out_q;
    soc_periph_pkg::gpio_word_t inten_q;
    soc_periph_pkg::gpio_word_t intstatus_q;
    soc_periph_pkg::gpio_word_t sync1_q;
    soc_periph_pkg::gpio_word_t sync2_q;
    soc_periph_pkg::gpio_word_t sync3_q;
    soc_periph_pkg::gpio_word_t rise;
    soc_periph_pkg::gpio_word_t int_clr;
    soc_periph_pkg::gpio_word_t wdata;
    logic                       gpio_event_q;
    logic                       wr_en;
    logic [RB-1:0]              offset;

    assign offset = bus.paddr[RB-1:0];
    assign wr_en  = bus.psel & bus.penable & bus.pwrite;
    assign wdata  = soc_periph_pkg::gpio_word_t'(bus.pwdata);

    // sync2 is the IN register, sync3 is the previous sample
    assign rise    = sync2_q & ~sync3_q & inten_q;
    assign int_clr = (wr_en && offset == `SOC_GPIO_INTSTATUS) ? wdata : '0;

    //////////////////////
    // input pipe
    //////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            sync3_q <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            sync3_q <= sync2_q;
        end
    end

    //////////////////////
    // registers
    //////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dir_q        <= '0;
            out_q        <= '0;
            inten_q      <= '0;
            intstatus_q  <= '0;
            gpio_event_q <= 1'b0;
        end else begin
            if (wr_en) begin
                case (offset)
                    `SOC_GPIO_DIR:   dir_q   <= wdata;
                    `SOC_GPIO_OUT:   out_q   <= wdata;
                    `SOC_GPIO_INTEN: inten_q <= wdata;
                    default: ;
                endcase
            end
            // a new edge wins over a clear in the same cycle
            intstatus_q  <= (intstatus_q & ~int_clr) | rise;
            gpio_event_q <= |rise;
        end
    end

    always_comb begin
        case (offset)
            `SOC_GPIO_DIR:       bus.prdata = soc_periph_pkg::apb_data_t'(dir_q);
            `SOC_GPIO_IN:        bus.prdata = soc_periph_pkg::apb_data_t'(sync2_q);
            `SOC_GPIO_OUT:       bus.prdata = soc_periph_pkg::apb_data_t'(out_q);
            `SOC_GPIO_INTEN:     bus.prdata = soc_periph_pkg::apb_data_t'(inten_q);
            `SOC_GPIO_INTSTATUS: bus.prdata = soc_periph_pkg::apb_data_t'(intstatus_q);
            default:             bus.prdata = '0;
        endcase
    end

    // no wait states
    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    assign gpio_out_o   = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = gpio_event_q;

    // a setup cycle is always followed by a completing access cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        (bus.psel && !bus.penable) |=> (bus.psel && bus.penable && bus.pready))
        else $error("gpio apb access cycle missing or stalled");

endmodule

// File: event_gen/soc_event_gen.sv
////////////////////
// soc event generator
// pending and mask per event, overrun flags, ref clock
// edge event and the id FIFO toward the fabric controller
////////////////////
`timescale 1ns/1ns
`include "soc_periph_settings.svh"

module soc_event_gen (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       slow_clk_i,
    input  soc_periph_pkg::event_vec_t events_i,
    input  logic                       fc_event_ready_i,
    apb_if.slave                       bus,
    output logic                       ref_edge_event_o,
    output logic                       err_event_o,
    output logic                       fc_event_valid_o,
    output soc_periph_pkg::event_id_t  fc_event_data_o
);

    localparam int RB      = `SOC_REGION_BITS;
    localparam int NUM     = `SOC_EVNT_NUM;
    localparam int ID_BITS = $clog2(NUM);
    localparam int DEPTH   = `SOC_EVT_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = $clog2(DEPTH + 1);

    logic [2:0]                 ref_q;
    soc_periph_pkg::event_vec_t mask_q;
    soc_periph_pkg::event_vec_t pend_q;
    soc_periph_pkg::event_vec_t err_q;
    logic                       err_event_q;
    soc_periph_pkg::event_vec_t sw_vec;
    soc_periph_pkg::event_vec_t src_vec;
    soc_periph_pkg::event_vec_t hit_vec;
    soc_periph_pkg::event_vec_t overrun;
    soc_periph_pkg::event_vec_t pop_vec;
    soc_periph_pkg::event_vec_t err_clr;
    logic [ID_BITS-1:0]         pick_idx;
    logic                       wr_en;
    logic [RB-1:0]              offset;

    soc_periph_pkg::event_id_t  fifo_mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [CNT_W-1:0]           cnt_q;
    logic                       fifo_full;
    logic                       fifo_push;
    logic                       fifo_pop;

    assign offset = bus.paddr[RB-1:0];
    assign wr_en  = bus.psel & bus.penable & bus.pwrite;

    // slow clock through two sync stages, third stage for the edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ref_q <= '0;
        end else begin
            ref_q <= {ref_q[1:0], slow_clk_i};
        end
    end
    assign ref_edge_event_o = ref_q[2] ^ ref_q[1];

    //////////////////////
    // sources and pending
    //////////////////////
    always_comb begin
        sw_vec = '0;
        if (wr_en && offset == `SOC_EVT_SW) begin
            sw_vec[bus.pwdata[ID_BITS-1:0]] = 1'b1;
        end
        src_vec = events_i | sw_vec;
        src_vec[`SOC_EVT_ID_REF] = src_vec[`SOC_EVT_ID_REF] | ref_edge_event_o;
    end

    assign hit_vec = src_vec & mask_q;
    assign err_clr = (wr_en && offset == `SOC_EVT_ERR) ?
                     bus.pwdata[NUM-1:0] : '0;

    // lowest pending id wins
    always_comb begin
        pick_idx = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                pick_idx = ID_BITS'(i);
            end
        end
    end

    assign fifo_full = (cnt_q == CNT_W'(DEPTH));
    assign fifo_push = (|pend_q) & ~fifo_full;
    assign pop_vec   = fifo_push ? (soc_periph_pkg::event_vec_t'(1) << pick_idx) : '0;
    // an id leaving for the FIFO this cycle may pend again without loss
    assign overrun   = hit_vec & pend_q & ~pop_vec;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q      <= '0;
            pend_q      <= '0;
            err_q       <= '0;
            err_event_q <= 1'b0;
        end else begin
            if (wr_en && offset == `SOC_EVT_MASK) begin
                mask_q <= bus.pwdata[NUM-1:0];
            end
            pend_q      <= (pend_q & ~pop_vec) | hit_vec;
            err_q       <= (err_q & ~err_clr) | overrun;
            err_event_q <= |overrun;
        end
    end
    assign err_event_o = err_event_q;

    //////////////////////
    // id FIFO
    //////////////////////
    assign fifo_pop = fc_event_valid_o & fc_event_ready_i;

    always_ff @(posedge clk_i) begin
        if (fifo_push) begin
            fifo_mem[wr_ptr_q] <= soc_periph_pkg::event_id_t'(pick_idx);
        end
    end

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (fifo_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(fifo_push) - CNT_W'(fifo_pop);
        end
    end

    assign fc_event_valid_o = (cnt_q != '0);
    assign fc_event_data_o  = fifo_mem[rd_ptr_q];

    always_comb begin
        case (offset)
            `SOC_EVT_MASK: bus.prdata = soc_periph_pkg::apb_data_t'(mask_q);
            `SOC_EVT_ERR:  bus.prdata = soc_periph_pkg::apb_data_t'(err_q);
            default:       bus.prdata = '0;
        endcase
    end
    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    // held output while the fabric controller stalls
    assert property (@(posedge clk_i) disable iff (reset_i)
        (fc_event_valid_o && !fc_event_ready_i) |=>
        (fc_event_valid_o && $stable(fc_event_data_o)))
        else $error("event output changed under back-pressure");

    // occupancy never passes the depth, so no push lands on a full FIFO
    assert property (@(posedge clk_i) disable iff (reset_i) cnt_q <= CNT_W'(DEPTH))
        else $error("event FIFO pushed while full");

endmodule

// File: src/soc_peripherals.sv
////////////////////
// soc peripheral subsystem top
// apb decoder, gpio and event generator, plus the fixed
// map onto the fabric controller event lines
////////////////////
`timescale 1ns/1ns
`include "soc_periph_settings.svh"

module soc_peripherals (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  soc_periph_pkg::apb_addr_t  paddr_i,
    input  soc_periph_pkg::apb_data_t  pwdata_i,
    input  logic                       pwrite_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    output soc_periph_pkg::apb_data_t  prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  soc_periph_pkg::gpio_word_t gpio_in_i,
    output soc_periph_pkg::gpio_word_t gpio_out_o,
    output soc_periph_pkg::gpio_word_t gpio_dir_o,
    input  logic                       slow_clk_i,
    input  logic                       dma_pe_evt_i,
    input  logic                       dma_pe_irq_i,
    output logic                       fc_event_valid_o,
    output soc_periph_pkg::event_id_t  fc_event_data_o,
    input  logic                       fc_event_ready_i,
    output soc_periph_pkg::fc_lines_t  fc_events_o
);

    apb_if gpio_bus ();
    apb_if evtgen_bus ();

    logic                       gpio_event;
    logic                       ref_edge_event;
    logic                       err_event;
    soc_periph_pkg::event_vec_t periph_events;

    periph_apb_decoder decoder_inst (
        .clk_i      ( clk_i      ),
        .paddr_i    ( paddr_i    ),
        .pwdata_i   ( pwdata_i   ),
        .pwrite_i   ( pwrite_i   ),
        .psel_i     ( psel_i     ),
        .penable_i  ( penable_i  ),
        .prdata_o   ( prdata_o   ),
        .pready_o   ( pready_o   ),
        .pslverr_o  ( pslverr_o  ),
        .gpio_bus   ( gpio_bus   ),
        .evtgen_bus ( evtgen_bus )
    );

    apb_gpio gpio_inst (
        .clk_i        ( clk_i      ),
        .reset_i      ( reset_i    ),
        .gpio_in_i    ( gpio_in_i  ),
        .bus          ( gpio_bus   ),
        .gpio_out_o   ( gpio_out_o ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    // raw sources, the ref clock event is formed inside the generator
    always_comb begin
        periph_events = '0;
        periph_events[`SOC_EVT_ID_DMA_PE]  = dma_pe_evt_i;
        periph_events[`SOC_EVT_ID_DMA_IRQ] = dma_pe_irq_i;
        periph_events[`SOC_EVT_ID_GPIO]    = gpio_event;
    end

    soc_event_gen event_gen_inst (
        .clk_i            ( clk_i            ),
        .reset_i          ( reset_i          ),
        .slow_clk_i       ( slow_clk_i       ),
        .events_i         ( periph_events    ),
        .fc_event_ready_i ( fc_event_ready_i ),
        .bus              ( evtgen_bus       ),
        .ref_edge_event_o ( ref_edge_event   ),
        .err_event_o      ( err_event        ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  )
    );

    // fixed line map of the non-ibex core, unused lines stay low
    always_comb begin
        fc_events_o = '0;
        fc_events_o[`SOC_FC_LINE_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[`SOC_FC_LINE_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[`SOC_FC_LINE_REF]     = ref_edge_event;
        fc_events_o[`SOC_FC_LINE_GPIO]    = gpio_event;
        fc_events_o[`SOC_FC_LINE_ERR]     = err_event;
    end

endmodule

// File: testbench/tb_soc_peripherals.sv
////////////////////
// soc peripherals testbench
// table driven apb accesses, pin and slow clock stimulus,
// event output and fabric controller line checks
////////////////////
`timescale 1ns/1ns
`include "soc_periph_settings.svh"

module tb_soc_peripherals;

    localparam int CLK_PERIOD = 4;
    localparam int WAIT_BOUND = 20;
    localparam logic [31:0] GPIO = `SOC_GPIO_BASE;
    localparam logic [31:0] EVT  = `SOC_EVTGEN_BASE;

    // row operations
    localparam logic [3:0] OP_WR        = 4'd0;
    localparam logic [3:0] OP_RD        = 4'd1;
    localparam logic [3:0] OP_RD_ERR    = 4'd2;
    localparam logic [3:0] OP_PINS      = 4'd3;
    localparam logic [3:0] OP_RAND_PINS = 4'd4;
    localparam logic [3:0] OP_RD_PINS   = 4'd5;
    localparam logic [3:0] OP_WAIT      = 4'd6;
    localparam logic [3:0] OP_SLOW      = 4'd7;
    localparam logic [3:0] OP_READY     = 4'd8;
    localparam logic [3:0] OP_EXP_EVT   = 4'd9;
    localparam logic [3:0] OP_EXP_LINE  = 4'd10;
    localparam logic [3:0] OP_IDLE      = 4'd11;
    localparam logic [3:0] OP_PORT      = 4'd12;

    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } row_t;

    logic        clk_i;
    logic        reset_i;
    logic [31:0] paddr_i;
    logic [31:0] pwdata_i;
    logic        pwrite_i;
    logic        psel_i;
    logic        penable_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [31:0] gpio_in_i;
    logic [31:0] gpio_out_o;
    logic [31:0] gpio_dir_o;
    logic        slow_clk_i;
    logic        dma_pe_evt_i;
    logic        dma_pe_irq_i;
    logic        fc_event_valid_o;
    logic [7:0]  fc_event_data_o;
    logic        fc_event_ready_i;
    logic [31:0] fc_events_o;

    row_t        rows [$];
    logic [31:0] last_pins;
    logic        table_built;
    longint      watchdog_ns;

    soc_peripherals soc_peripherals_inst (
        .clk_i            ( clk_i            ),
        .reset_i          ( reset_i          ),
        .paddr_i          ( paddr_i          ),
        .pwdata_i         ( pwdata_i         ),
        .pwrite_i         ( pwrite_i         ),
        .psel_i           ( psel_i           ),
        .penable_i        ( penable_i        ),
        .prdata_o         ( prdata_o         ),
        .pready_o         ( pready_o         ),
        .pslverr_o        ( pslverr_o        ),
        .gpio_in_i        ( gpio_in_i        ),
        .gpio_out_o       ( gpio_out_o       ),
        .gpio_dir_o       ( gpio_dir_o       ),
        .slow_clk_i       ( slow_clk_i       ),
        .dma_pe_evt_i     ( dma_pe_evt_i     ),
        .dma_pe_irq_i     ( dma_pe_irq_i     ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .fc_event_ready_i ( fc_event_ready_i ),
        .fc_events_o      ( fc_events_o      )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////
    // helpers
    //////////////////////
    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t signal %s got 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // setup cycle then access cycle with the response sampled mid access
    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk_i);
        paddr_i   <= addr;
        pwdata_i  <= data;
        pwrite_i  <= wr;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        check_value("pready_o", pready_o, 1'b1);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    // line below zero waits for fc_event_valid_o, else for that fc line
    task automatic wait_for_event(input int row, input int line);
        int   cycles;
        logic hit;
        cycles = 0;
        @(negedge clk_i);
        hit = (line < 0) ? fc_event_valid_o : fc_events_o[line];
        while (!hit) begin
            if (cycles == WAIT_BOUND) begin
                $display("timeout in row %0d, no event seen within %0d cycles", row, cycles);
                abort_run();
            end else begin
                cycles++;
                @(negedge clk_i);
                hit = (line < 0) ? fc_event_valid_o : fc_events_o[line];
            end
        end
    endtask

    task automatic add_row(input logic [3:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
        rows.push_back({op, addr, data, exp});
    endtask

    //////////////////////
    // stimulus table
    //////////////////////
    task automatic build_table();
        // direction and output registers
        add_row(OP_WR,   GPIO + `SOC_GPIO_DIR, 32'h0000_FF0F, 0);
        add_row(OP_WR,   GPIO + `SOC_GPIO_OUT, 32'hA5A5_0F0F, 0);
        add_row(OP_RD,   GPIO + `SOC_GPIO_DIR, 0, 32'h0000_FF0F);
        add_row(OP_RD,   GPIO + `SOC_GPIO_OUT, 0, 32'hA5A5_0F0F);
        add_row(OP_PORT, `SOC_GPIO_DIR, 0, 32'h0000_FF0F);
        add_row(OP_PORT, `SOC_GPIO_OUT, 0, 32'hA5A5_0F0F);
        // random pin patterns through the synchroniser
        add_row(OP_RAND_PINS, 0, 0, 0);
        add_row(OP_WAIT,      0, 3, 0);
        add_row(OP_RD_PINS,   GPIO + `SOC_GPIO_IN, 0, 0);
        add_row(OP_RAND_PINS, 0, 0, 0);
        add_row(OP_WAIT,      0, 3, 0);
        add_row(OP_RD_PINS,   GPIO + `SOC_GPIO_IN, 0, 0);
        // rising edge on pin 7 with its interrupt enabled
        add_row(OP_PINS,     0, 0, 0);
        add_row(OP_WAIT,     0, 4, 0);
        add_row(OP_WR,       GPIO + `SOC_GPIO_INTEN, 32'h80, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_MASK, 32'h08, 0);
        add_row(OP_PINS,     0, 32'h80, 0);
        add_row(OP_EXP_LINE, 0, `SOC_FC_LINE_GPIO, 0);
        add_row(OP_RD,       GPIO + `SOC_GPIO_INTSTATUS, 0, 32'h80);
        add_row(OP_WR,       GPIO + `SOC_GPIO_INTSTATUS, 32'h80, 0);
        add_row(OP_RD,       GPIO + `SOC_GPIO_INTSTATUS, 0, 0);
        add_row(OP_READY,    0, 1, 0);
        add_row(OP_EXP_EVT,  0, 0, `SOC_EVT_ID_GPIO);
        add_row(OP_READY,    0, 0, 0);
        add_row(OP_IDLE,     0, 4, 0);
        // software events queue in write order and masked id 7 is dropped
        add_row(OP_WR,      EVT + `SOC_EVT_MASK, 32'h62, 0);
        add_row(OP_WR,      EVT + `SOC_EVT_SW, 5, 0);
        add_row(OP_WR,      EVT + `SOC_EVT_SW, 1, 0);
        add_row(OP_WR,      EVT + `SOC_EVT_SW, 6, 0);
        add_row(OP_WR,      EVT + `SOC_EVT_SW, 7, 0);
        add_row(OP_READY,   0, 1, 0);
        add_row(OP_EXP_EVT, 0, 0, 5);
        add_row(OP_EXP_EVT, 0, 0, 1);
        add_row(OP_EXP_EVT, 0, 0, 6);
        add_row(OP_READY,   0, 0, 0);
        add_row(OP_IDLE,    0, 8, 0);
        // full FIFO, one pending id and its overrun
        add_row(OP_WR,       EVT + `SOC_EVT_MASK, 32'hF2, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_SW, 4, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_SW, 5, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_SW, 6, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_SW, 7, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_SW, 1, 0);
        add_row(OP_RD,       EVT + `SOC_EVT_ERR, 0, 0);
        add_row(OP_WR,       EVT + `SOC_EVT_SW, 1, 0);
        add_row(OP_EXP_LINE, 0, `SOC_FC_LINE_ERR, 0);
        add_row(OP_RD,       EVT + `SOC_EVT_ERR, 0, 32'h02);
        add_row(OP_WR,       EVT + `SOC_EVT_ERR, 32'h02, 0);
        add_row(OP_RD,       EVT + `SOC_EVT_ERR, 0, 0);
        add_row(OP_READY,    0, 1, 0);
        add_row(OP_EXP_EVT,  0, 0, 4);
        add_row(OP_EXP_EVT,  0, 0, 5);
        add_row(OP_EXP_EVT,  0, 0, 6);
        add_row(OP_EXP_EVT,  0, 0, 7);
        add_row(OP_EXP_EVT,  0, 0, 1);
        add_row(OP_READY,    0, 0, 0);
        add_row(OP_IDLE,     0, 4, 0);
        // unmapped region and the reference clock event
        add_row(OP_RD_ERR,   32'h1A10_3000, 0, 0);
        add_row(OP_WR,       32'h1A10_4000, 32'h1234, 1);
        add_row(OP_WR,       EVT + `SOC_EVT_MASK, 32'h04, 0);
        add_row(OP_SLOW,     0, 0, 0);
        add_row(OP_EXP_LINE, 0, `SOC_FC_LINE_REF, 0);
        add_row(OP_READY,    0, 1, 0);
        add_row(OP_EXP_EVT,  0, 0, `SOC_EVT_ID_REF);
        add_row(OP_READY,    0, 0, 0);
        add_row(OP_IDLE,     0, 4, 0);
    endtask

    task automatic run_row(input int idx, input row_t r);
        logic [31:0] rdata;
        logic        err;
        case (r.op)
            OP_WR: begin
                apb_transfer(1'b1, r.addr, r.data, rdata, err);
                check_value("pslverr_o", err, r.exp);
            end
            OP_RD, OP_RD_ERR, OP_RD_PINS: begin
                apb_transfer(1'b0, r.addr, 0, rdata, err);
                check_value("prdata_o", rdata, (r.op == OP_RD_PINS) ? last_pins : r.exp);
                check_value("pslverr_o", err, r.op == OP_RD_ERR);
            end
            OP_PINS, OP_RAND_PINS: begin
                @(posedge clk_i);
                last_pins = (r.op == OP_RAND_PINS) ? $urandom : r.data;
                gpio_in_i <= last_pins;
            end
            OP_WAIT: repeat (r.data) @(posedge clk_i);
            OP_SLOW: begin
                @(posedge clk_i);
                slow_clk_i <= ~slow_clk_i;
            end
            OP_READY: begin
                @(posedge clk_i);
                fc_event_ready_i <= r.data[0];
            end
            OP_EXP_EVT: begin
                wait_for_event(idx, -1);
                check_value("fc_event_data_o", fc_event_data_o, r.exp);
            end
            OP_EXP_LINE: wait_for_event(idx, int'(r.data));
            OP_IDLE: begin
                repeat (r.data) begin
                    @(negedge clk_i);
                    check_value("fc_event_valid_o", fc_event_valid_o, 1'b0);
                end
            end
            OP_PORT: begin
                @(negedge clk_i);
                if (r.addr == `SOC_GPIO_DIR) begin
                    check_value("gpio_dir_o", gpio_dir_o, r.exp);
                end else begin
                    check_value("gpio_out_o", gpio_out_o, r.exp);
                end
            end
            default: begin
                $display("row %0d holds an unknown operation", idx);
                abort_run();
            end
        endcase
    endtask

    //////////////////////
    // main sequence
    //////////////////////
    initial begin
        clk_i            = 1'b0;
        reset_i          = 1'b1;
        paddr_i          = '0;
        pwdata_i         = '0;
        pwrite_i         = 1'b0;
        psel_i           = 1'b0;
        penable_i        = 1'b0;
        gpio_in_i        = '0;
        slow_clk_i       = 1'b0;
        dma_pe_evt_i     = 1'b0;
        dma_pe_irq_i     = 1'b0;
        fc_event_ready_i = 1'b0;
        last_pins        = '0;
        table_built      = 1'b0;
        void'($urandom(32'h42ac));
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        // reset state
        check_value("fc_event_valid_o", fc_event_valid_o, 1'b0);
        check_value("fc_events_o", fc_events_o, 0);
        check_value("gpio_dir_o", gpio_dir_o, 0);
        check_value("gpio_out_o", gpio_out_o, 0);
        check_value("pslverr_o", pslverr_o, 1'b0);
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // watchdog allows 40 cycles per table row
    initial begin
        wait (table_built);
        watchdog_ns = rows.size() * 40 * CLK_PERIOD;
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the table did not complete", watchdog_ns);
        abort_run();
    end

endmodule

// File: vlog.f
+incdir+common
common/soc_periph_pkg.sv
common/apb_if.sv
src/periph_apb_decoder.sv
gpio/apb_gpio.sv
event_gen/soc_event_gen.sv
src/soc_peripherals.sv
testbench/tb_soc_peripherals.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f vlog.f \
    --top-module tb_soc_peripherals -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }
